// ==== hw/core_settings.svh ====
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// physical register file banking
`define PRF_BANK_COUNT 4
`define LOG_PRF_BANK_COUNT 2

// physical registers
`define PR_COUNT 64
`define LOG_PR_COUNT 6

// reorder buffer
`define ROB_ENTRIES 32
`define LOG_ROB_ENTRIES 5

`endif

// ==== hw/core_types_pkg.sv ====
`default_nettype none

`include "core_settings.svh"

package core_types_pkg;

	// ------------------------------
	// widths shared across the core
	// ------------------------------

	// architectural data word
	typedef logic [31:0] word_t;

	// physical register index
	typedef logic [`LOG_PR_COUNT-1:0] pr_idx_t;

	// reorder buffer slot
	typedef logic [`LOG_ROB_ENTRIES-1:0] rob_idx_t;

	// PRF bank select
	// low bits of the PR index pick the bank
	typedef logic [`LOG_PRF_BANK_COUNT-1:0] bank_idx_t;

endpackage

`default_nettype wire

// ==== hw/alu_pkg.sv ====
`default_nettype none

`include "core_settings.svh"

package alu_pkg;

	import core_types_pkg::*;

	// ------------------------------
	// ALU op encoding
	// ------------------------------

	// {funct7[5], funct3}
	typedef enum logic [3:0] {
		ALU_ADD  = 4'b0000,
		ALU_SUB  = 4'b1000,
		ALU_SLL  = 4'b0001,
		ALU_SLT  = 4'b0010,
		ALU_SLTU = 4'b0011,
		ALU_XOR  = 4'b0100,
		ALU_SRL  = 4'b0101,
		ALU_SRA  = 4'b1101,
		ALU_OR   = 4'b0110,
		ALU_AND  = 4'b0111
	} alu_op_t;

	// ------------------------------
	// pipeline payloads
	// ------------------------------

	// op from the issue queue
	// forward bit set means operand comes off the forwarding bus
	typedef struct packed {
		alu_op_t op;
		logic A_forward;
		bank_idx_t A_bank;
		logic B_forward;
		bank_idx_t B_bank;
		pr_idx_t dest_PR;
		rob_idx_t ROB_index;
	} alu_issue_t;

	// result back to the PRF
	typedef struct packed {
		word_t data;
		pr_idx_t PR;
		rob_idx_t ROB_index;
	} alu_wb_t;

	// PRF read ports, indexed [bank][port]
	typedef word_t [`PRF_BANK_COUNT-1:0][1:0] reg_read_data_t;

	// forwarding bus, one word per bank
	typedef word_t [`PRF_BANK_COUNT-1:0] forward_data_t;

endpackage

`default_nettype wire

// ==== hw/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu
	import core_types_pkg::*;
	import alu_pkg::*;
(
	input alu_op_t op,
	input word_t A,
	input word_t B,
	output word_t result
);

	// only low five bits of B shift
	logic [4:0] shamt;

	assign shamt = B[4:0];

	always_comb begin
		case (op)
			ALU_ADD:  result = A + B;
			ALU_SUB:  result = A - B;
			ALU_SLL:  result = A << shamt;
			// signed compare
			ALU_SLT:  result = {31'b0, $signed(A) < $signed(B)};
			// unsigned compare
			ALU_SLTU: result = {31'b0, A < B};
			ALU_XOR:  result = A ^ B;
			ALU_SRL:  result = A >> shamt;
			// sign bit fills from the left
			ALU_SRA:  result = word_t'($signed(A) >>> shamt);
			ALU_OR:   result = A | B;
			ALU_AND:  result = A & B;
			// reserved encodings
			default:  result = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== hw/alu_reg_pipeline.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_reg_pipeline
	import core_types_pkg::*;
	import alu_pkg::*;
(
	input logic CLK,
	input logic nRST,

	// op issue from issue queue
	input logic issue_valid,
	input alu_issue_t issue,
	output logic issue_ready,

	// read acks and data from PRF
	input logic A_reg_read_ack,
	input logic A_reg_read_port,
	input logic B_reg_read_ack,
	input logic B_reg_read_port,
	input reg_read_data_t reg_read_data,

	// forwarding bus
	input forward_data_t forward_data,

	// writeback to PRF
	output logic WB_valid,
	output alu_wb_t WB,
	input logic WB_ready
);

	// ------------------------------
	// operand collect
	// ------------------------------

	// stage occupancy
	logic oc_valid;
	// first cycle after issue, forward bus valid only here
	logic oc_first;
	alu_issue_t oc_op;

	// index 0 is A, index 1 is B
	logic [1:0] opnd_forward;
	logic [1:0] opnd_ack;
	logic [1:0] opnd_port;
	bank_idx_t [1:0] opnd_bank;
	logic [1:0] opnd_collected;
	logic [1:0] opnd_arriving;
	logic [1:0] opnd_in_hand;
	word_t [1:0] opnd_data;
	word_t [1:0] opnd_value;

	// stall control
	logic wb_free;
	logic oc_move;
	word_t alu_result;

	assign opnd_forward = {oc_op.B_forward, oc_op.A_forward};
	assign opnd_bank = {oc_op.B_bank, oc_op.A_bank};
	assign opnd_ack = {B_reg_read_ack, A_reg_read_ack};
	assign opnd_port = {B_reg_read_port, A_reg_read_port};

	always_comb begin
		for (int i = 0; i < 2; i++) begin
			// forwarded operand lands in first cycle, read operand on its ack
			opnd_arriving[i] = oc_valid & ~opnd_collected[i]
				& (opnd_forward[i] ? oc_first : opnd_ack[i]);
			opnd_in_hand[i] = opnd_collected[i] | opnd_arriving[i];
			// held copy wins once collected
			if (opnd_collected[i])
				opnd_value[i] = opnd_data[i];
			else if (opnd_forward[i])
				opnd_value[i] = forward_data[opnd_bank[i]];
			else
				opnd_value[i] = reg_read_data[opnd_bank[i]][opnd_port[i]];
		end
	end

	// one op at a time in collect
	assign issue_ready = ~oc_valid;

	// writeback slot open if empty or draining this cycle
	assign wb_free = ~WB_valid | WB_ready;
	assign oc_move = oc_valid & (&opnd_in_hand) & wb_free;

	always_ff @(posedge CLK, negedge nRST) begin
		if (~nRST) begin
			oc_valid <= 1'b0;
			oc_first <= 1'b0;
			opnd_collected <= '0;
		end
		else begin
			oc_first <= 1'b0;
			if (issue_valid) begin
				oc_valid <= 1'b1;
				oc_first <= 1'b1;
				opnd_collected <= '0;
			end
			else begin
				if (oc_move)
					oc_valid <= 1'b0;
				opnd_collected <= opnd_collected | opnd_arriving;
			end
		end
	end

	// op fields and operand words
	always_ff @(posedge CLK) begin
		if (issue_valid)
			oc_op <= issue;
		for (int i = 0; i < 2; i++) begin
			if (opnd_arriving[i])
				opnd_data[i] <= opnd_value[i];
		end
	end

	// ------------------------------
	// execute
	// ------------------------------

	alu alu_inst (
		.op(oc_op.op),
		.A(opnd_value[0]),
		.B(opnd_value[1]),
		.result(alu_result)
	);

	// ------------------------------
	// writeback
	// ------------------------------

	// valid holds until PRF takes it
	always_ff @(posedge CLK, negedge nRST) begin
		if (~nRST)
			WB_valid <= 1'b0;
		else if (oc_move)
			WB_valid <= 1'b1;
		else if (WB_ready)
			WB_valid <= 1'b0;
	end

	// result only loads on a move, stable under back-pressure
	always_ff @(posedge CLK) begin
		if (oc_move) begin
			WB.data <= alu_result;
			WB.PR <= oc_op.dest_PR;
			WB.ROB_index <= oc_op.ROB_index;
		end
	end

endmodule

`default_nettype wire

// ==== hw/alu_reg_pipeline_wrapper.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_reg_pipeline_wrapper
	import alu_pkg::*;
(
	input logic CLK,
	input logic nRST,

	// issue queue side
	input logic next_issue_valid,
	input alu_issue_t next_issue,
	output logic last_issue_ready,

	// PRF read side
	input logic next_A_reg_read_ack,
	input logic next_A_reg_read_port,
	input logic next_B_reg_read_ack,
	input logic next_B_reg_read_port,
	input reg_read_data_t next_reg_read_data,
	input forward_data_t next_forward_data,

	// PRF writeback side
	output logic last_WB_valid,
	output alu_wb_t last_WB,
	input logic next_WB_ready
);

	// ------------------------------
	// pipeline-side copies
	// ------------------------------

	logic issue_valid;
	alu_issue_t issue;
	logic issue_ready;
	logic A_reg_read_ack;
	logic A_reg_read_port;
	logic B_reg_read_ack;
	logic B_reg_read_port;
	reg_read_data_t reg_read_data;
	forward_data_t forward_data;
	logic WB_valid;
	alu_wb_t WB;
	logic WB_ready;

	alu_reg_pipeline pipeline (
		.CLK(CLK),
		.nRST(nRST),
		.issue_valid(issue_valid),
		.issue(issue),
		.issue_ready(issue_ready),
		.A_reg_read_ack(A_reg_read_ack),
		.A_reg_read_port(A_reg_read_port),
		.B_reg_read_ack(B_reg_read_ack),
		.B_reg_read_port(B_reg_read_port),
		.reg_read_data(reg_read_data),
		.forward_data(forward_data),
		.WB_valid(WB_valid),
		.WB(WB),
		.WB_ready(WB_ready)
	);

	// ------------------------------
	// boundary flops
	// ------------------------------

	// one stage each way, pins never reach pipeline logic directly
	always_ff @(posedge CLK, negedge nRST) begin
		if (~nRST) begin
			issue_valid <= 1'b0;
			issue <= '0;
			A_reg_read_ack <= 1'b0;
			A_reg_read_port <= 1'b0;
			B_reg_read_ack <= 1'b0;
			B_reg_read_port <= 1'b0;
			reg_read_data <= '0;
			forward_data <= '0;
			WB_ready <= 1'b0;
			// outputs
			last_issue_ready <= 1'b0;
			last_WB_valid <= 1'b0;
			last_WB <= '0;
		end
		else begin
			issue_valid <= next_issue_valid;
			issue <= next_issue;
			A_reg_read_ack <= next_A_reg_read_ack;
			A_reg_read_port <= next_A_reg_read_port;
			B_reg_read_ack <= next_B_reg_read_ack;
			B_reg_read_port <= next_B_reg_read_port;
			reg_read_data <= next_reg_read_data;
			forward_data <= next_forward_data;
			WB_ready <= next_WB_ready;
			// outputs
			last_issue_ready <= issue_ready;
			last_WB_valid <= WB_valid;
			last_WB <= WB;
		end
	end

endmodule

`default_nettype wire

// ==== tests/alu_reg_pipeline_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_reg_pipeline_assert
	import alu_pkg::*;
(
	input logic CLK,
	input logic nRST,
	input logic issue_valid,
	input logic issue_ready,
	input logic WB_valid,
	input alu_wb_t WB,
	input logic WB_ready,
	input logic A_reg_read_ack,
	input logic B_reg_read_ack,
	input logic oc_valid,
	// index 0 is A, index 1 is B
	input logic [1:0] opnd_forward,
	input logic [1:0] opnd_collected
);

	// ------------------------------
	// handshake rules
	// ------------------------------

	// no retry on issue
	issue_only_when_ready: assert property (@(posedge CLK) disable iff (!nRST)
		issue_valid |-> issue_ready)
		else $error("issue_valid high while issue_ready low");

	// held result stays put
	wb_held_stable: assert property (@(posedge CLK) disable iff (!nRST)
		(WB_valid && !WB_ready) |=> (WB_valid && $stable(WB)))
		else $error("writeback changed while held by back-pressure");

	// ack only for a read operand still waiting
	a_ack_when_waiting: assert property (@(posedge CLK) disable iff (!nRST)
		A_reg_read_ack |-> (oc_valid && !opnd_forward[0] && !opnd_collected[0]))
		else $error("A read ack for an operand that is not waiting");

	b_ack_when_waiting: assert property (@(posedge CLK) disable iff (!nRST)
		B_reg_read_ack |-> (oc_valid && !opnd_forward[1] && !opnd_collected[1]))
		else $error("B read ack for an operand that is not waiting");

endmodule

bind alu_reg_pipeline alu_reg_pipeline_assert pipeline_checks (
	.CLK(CLK),
	.nRST(nRST),
	.issue_valid(issue_valid),
	.issue_ready(issue_ready),
	.WB_valid(WB_valid),
	.WB(WB),
	.WB_ready(WB_ready),
	.A_reg_read_ack(A_reg_read_ack),
	.B_reg_read_ack(B_reg_read_ack),
	.oc_valid(oc_valid),
	.opnd_forward(opnd_forward),
	.opnd_collected(opnd_collected)
);

`default_nettype wire

// ==== tests/alu_reg_pipeline_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module alu_reg_pipeline_tb
	import core_types_pkg::*;
	import alu_pkg::*;
();

	localparam int NUM_OPS = 300;
	localparam int TIMEOUT_CYCLES = NUM_OPS * 40;

	logic CLK;
	logic nRST;
	logic next_issue_valid;
	alu_issue_t next_issue;
	logic last_issue_ready;
	logic next_A_reg_read_ack;
	logic next_A_reg_read_port;
	logic next_B_reg_read_ack;
	logic next_B_reg_read_port;
	reg_read_data_t next_reg_read_data;
	forward_data_t next_forward_data;
	logic last_WB_valid;
	alu_wb_t last_WB;
	logic next_WB_ready;

	// ------------------------------
	// model state
	// ------------------------------

	logic [31:0] lfsr = 32'hee0f;
	// expected writebacks in issue order with a test name each
	alu_wb_t exp_q[$];
	string name_q[$];
	int value_errors = 0;
	int other_errors = 0;
	int issued = 0;
	int written = 0;
	int cycles = 0;
	int cyc = 0;
	int last_issue_cyc = -10;
	// schedule of the op now in operand collect
	int fwd_cyc = -1;
	int a_ack_cyc = -1;
	int b_ack_cyc = -1;
	logic a_fwd;
	logic b_fwd;
	logic a_port;
	logic b_port;
	bank_idx_t a_bank;
	bank_idx_t b_bank;
	word_t a_val;
	word_t b_val;
	// WB_ready seen one and two cycles back
	logic ready_d1 = 1'b0;
	logic ready_d2 = 1'b0;

	alu_reg_pipeline_wrapper dut (
		.CLK(CLK),
		.nRST(nRST),
		.next_issue_valid(next_issue_valid),
		.next_issue(next_issue),
		.last_issue_ready(last_issue_ready),
		.next_A_reg_read_ack(next_A_reg_read_ack),
		.next_A_reg_read_port(next_A_reg_read_port),
		.next_B_reg_read_ack(next_B_reg_read_ack),
		.next_B_reg_read_port(next_B_reg_read_port),
		.next_reg_read_data(next_reg_read_data),
		.next_forward_data(next_forward_data),
		.last_WB_valid(last_WB_valid),
		.last_WB(last_WB),
		.next_WB_ready(next_WB_ready)
	);

	always #5 CLK = ~CLK;

	// fibonacci LFSR on taps 32 22 2 1 stepping once per bit
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		logic fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	// RV32 register-register result
	function automatic word_t expected_result(input alu_op_t op, input word_t a, input word_t b);
		logic [4:0] sh;
		word_t r;
		sh = b[4:0];
		case (op)
			ALU_ADD: r = a + b;
			ALU_SUB: r = a + ~b + 32'd1;
			ALU_SLL: r = a << sh;
			// when signs differ the negative one is smaller
			ALU_SLT: r = (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
			ALU_SLTU: r = {31'b0, a < b};
			ALU_XOR: r = a ^ b;
			ALU_SRL: r = a >> sh;
			// fill vacated top bits with the sign
			ALU_SRA: r = (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
			ALU_OR: r = a | b;
			ALU_AND: r = a & b;
			default: r = '0;
		endcase
		return r;
	endfunction

	task automatic check_reset_outputs(input string name);
		if (last_WB_valid !== 1'b0) begin
			$display("error %s: last_WB_valid expected 0 actual %b", name, last_WB_valid);
			value_errors++;
		end
		if (last_issue_ready !== 1'b0) begin
			$display("error %s: last_issue_ready expected 0 actual %b", name, last_issue_ready);
			value_errors++;
		end
	endtask

	// issue queue model picks op and operands and PRF timing
	task automatic issue_op();
		alu_issue_t iss;
		alu_wb_t exp;
		string name;
		iss.op = alu_op_t'(4'(take_bits(4)));
		iss.A_forward = 1'(take_bits(1));
		iss.A_bank = bank_idx_t'(take_bits(`LOG_PRF_BANK_COUNT));
		iss.B_forward = 1'(take_bits(1));
		iss.B_bank = bank_idx_t'(take_bits(`LOG_PRF_BANK_COUNT));
		iss.dest_PR = pr_idx_t'(take_bits(`LOG_PR_COUNT));
		iss.ROB_index = rob_idx_t'(take_bits(`LOG_ROB_ENTRIES));
		a_fwd = iss.A_forward;
		b_fwd = iss.B_forward;
		a_bank = iss.A_bank;
		b_bank = iss.B_bank;
		a_val = take_bits(32);
		b_val = take_bits(32);
		a_port = 1'(take_bits(1));
		b_port = 1'(take_bits(1));
		// ack 1 to 4 cycles after issue
		a_ack_cyc = cyc + 1 + int'(take_bits(2));
		b_ack_cyc = cyc + 1 + int'(take_bits(2));
		fwd_cyc = cyc + 1;
		// both operands see the same word when they share a bus slot
		if (a_fwd && b_fwd && a_bank == b_bank)
			b_val = a_val;
		if (!a_fwd && !b_fwd && a_ack_cyc == b_ack_cyc && a_bank == b_bank && a_port == b_port)
			b_val = a_val;
		exp.data = expected_result(iss.op, a_val, b_val);
		exp.PR = iss.dest_PR;
		exp.ROB_index = iss.ROB_index;
		if (a_fwd && b_fwd)
			name = "forward";
		else if (!a_fwd && !b_fwd)
			name = "reg_read";
		else
			name = "mixed";
		exp_q.push_back(exp);
		name_q.push_back($sformatf("%s %s", name, iss.op.name()));
		next_issue_valid = 1'b1;
		next_issue = iss;
		last_issue_cyc = cyc;
		issued++;
	endtask

	// PRF model drives junk everywhere except the acked slot
	task automatic drive_prf();
		for (int b = 0; b < `PRF_BANK_COUNT; b++) begin
			next_forward_data[bank_idx_t'(b)] = take_bits(32);
			for (int p = 0; p < 2; p++)
				next_reg_read_data[bank_idx_t'(b)][1'(p)] = take_bits(32);
		end
		next_A_reg_read_ack = 1'b0;
		next_B_reg_read_ack = 1'b0;
		next_A_reg_read_port = 1'(take_bits(1));
		next_B_reg_read_port = 1'(take_bits(1));
		if (cyc == fwd_cyc && a_fwd)
			next_forward_data[a_bank] = a_val;
		if (cyc == fwd_cyc && b_fwd)
			next_forward_data[b_bank] = b_val;
		if (cyc == a_ack_cyc && !a_fwd) begin
			next_A_reg_read_ack = 1'b1;
			next_A_reg_read_port = a_port;
			next_reg_read_data[a_bank][a_port] = a_val;
		end
		if (cyc == b_ack_cyc && !b_fwd) begin
			next_B_reg_read_ack = 1'b1;
			next_B_reg_read_port = b_port;
			next_reg_read_data[b_bank][b_port] = b_val;
		end
		// ready about three cycles in four
		next_WB_ready = (take_bits(2) != 0);
	endtask

	initial begin
		CLK = 1'b0;
		nRST = 1'b0;
		next_issue_valid = 1'b0;
		next_issue = '0;
		next_A_reg_read_ack = 1'b0;
		next_A_reg_read_port = 1'b0;
		next_B_reg_read_ack = 1'b0;
		next_B_reg_read_port = 1'b0;
		next_reg_read_data = '0;
		next_forward_data = '0;
		next_WB_ready = 1'b0;
		@(posedge CLK);
		#4;
		check_reset_outputs("reset");
		@(posedge CLK);
		#1;
		nRST = 1'b1;
		#4;
		check_reset_outputs("first cycle after reset");
		@(posedge CLK);
		#1;
		if (last_issue_ready !== 1'b1) begin
			$display("error second cycle after reset: last_issue_ready expected 1 actual %b",
				last_issue_ready);
			value_errors++;
		end
		// no issue in either of the two cycles before
		while (issued < NUM_OPS || exp_q.size() != 0) begin
			next_issue_valid = 1'b0;
			if (issued < NUM_OPS && last_issue_ready && cyc - last_issue_cyc > 2)
				issue_op();
			drive_prf();
			cyc++;
			@(posedge CLK);
			#1;
		end
		next_issue_valid = 1'b0;
		next_WB_ready = 1'b1;
		// idle tail catches stray writebacks
		repeat (10) @(posedge CLK);
		#1;
		$display("%0d value errors, %0d other errors, %0d of %0d ops written back",
			value_errors, other_errors, written, NUM_OPS);
		if (value_errors + other_errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

	// ------------------------------
	// writeback compare
	// ------------------------------

	// accepted when ready was driven two cycles before
	always @(negedge CLK) begin : compare_wb
		alu_wb_t exp;
		string name;
		if (nRST) begin
			if (last_WB_valid && ready_d2) begin
				if (exp_q.size() == 0) begin
					$display("writeback of PR %0d appeared with no op outstanding", last_WB.PR);
					other_errors++;
				end
				else begin
					exp = exp_q.pop_front();
					name = name_q.pop_front();
					written++;
					if (last_WB !== exp) begin
						$display("error %s: expected %h PR %0d ROB %0d actual %h PR %0d ROB %0d",
							name, exp.data, exp.PR, exp.ROB_index,
							last_WB.data, last_WB.PR, last_WB.ROB_index);
						value_errors++;
					end
				end
			end
			ready_d2 = ready_d1;
			ready_d1 = next_WB_ready;
		end
	end

	// run limit
	always @(posedge CLK) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles, %0d of %0d ops written back",
				cycles, written, NUM_OPS);
			$display("** FAIL **");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+hw
hw/core_types_pkg.sv
hw/alu_pkg.sv
hw/alu.sv
hw/alu_reg_pipeline.sv
hw/alu_reg_pipeline_wrapper.sv
tests/alu_reg_pipeline_assert.sv
tests/alu_reg_pipeline_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= alu_reg_pipeline_tb
FILELIST ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
PASS_TEXT ?= ** PASS **

SIM := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard hw/*.sv hw/*.svh tests/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# status comes from the search for the pass line
run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qF -- '$(PASS_TEXT)'

clean:
	rm -rf $(BUILD_DIR)
